// File: rtl/ppu_mem_params.svh
`ifndef PPU_MEM_PARAMS_SVH
`define PPU_MEM_PARAMS_SVH

// Address widths of the PPU memory side

// Full PPU address space, 0000 to 3FFF
`define PPU_ADDR_WIDTH 14

// Pattern store, 8 KB
`define CHR_WIDTH 13

// Nametable VRAM, 2 KB (two physical tables)
`define VRAM_WIDTH 11

// Palette RAM, 32 bytes
`define PAL_WIDTH 5

// Sprite attribute memory, 64 sprites of 4 bytes
`define OAM_WIDTH 8

`endif

// File: rtl/ppu_mem_pkg.sv
`include "ppu_mem_params.svh"

package ppu_mem_pkg;

    // CPU visible PPU register numbers
    typedef enum logic [2:0] {
        REG_CTRL    = 3'd0, // Only bit 2 kept
        REG_OAMADDR = 3'd3,
        REG_OAMDATA = 3'd4,
        REG_ADDR    = 3'd6, // Two writes, high byte first
        REG_DATA    = 3'd7
    } ppu_reg_e;

    typedef struct packed {
        logic       wr;      // Write strobe
        logic       rd;      // Read strobe
        ppu_reg_e   reg_sel;
        logic [7:0] wdata;
    } cpu_req_t;

    // Pattern and nametable view
    typedef struct packed {
        logic [1:0] region;  // 0,1 pattern, 2,3 nametable
        logic [1:0] nt_sel;  // Logical nametable
        logic [9:0] offset;
    } ppu_nt_t;

    // Palette view
    typedef struct packed {
        logic [8:0] page;    // 1F8..1FF is 3F00..3FFF
        logic [4:0] pal_idx;
    } ppu_pal_t;

    typedef union packed {
        logic [`PPU_ADDR_WIDTH-1:0] raw;
        ppu_nt_t                    nt;
        ppu_pal_t                   pal;
    } ppu_addr_u;

    typedef struct packed {
        ppu_addr_u  addr;    // Current VRAM address
        logic [7:0] data;
        logic       we;      // CHR, VRAM or palette write
        logic       oam_we;  // OAM write at oam_addr
    } mem_wr_t;

endpackage

// File: rtl/ppu_mems.sv
`include "ppu_mem_params.svh"

// 8 KB pattern store, CPU writes on port 1, render reads on port 2
module chr_ram (
    input  logic                  clk,
    input  logic                  clk_en, // PPU clock, master/4
    input  logic                  rst_n,
    input  logic [`CHR_WIDTH-1:0] addr1,
    input  logic [`CHR_WIDTH-1:0] addr2,
    input  logic                  we1,
    input  logic [7:0]            data_in1,
    output logic [7:0]            data_out1,
    output logic [7:0]            data_out2
);

    logic [7:0] mem [2**`CHR_WIDTH];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**`CHR_WIDTH; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (clk_en && we1) begin
            mem[addr1] <= data_in1;
        end
    end

    assign data_out1 = mem[addr1];
    assign data_out2 = mem[addr2];

endmodule

// Two physical nametables, true dual port
module vram (
    input  logic                   clk,
    input  logic                   clk_en,
    input  logic                   rst_n,
    input  logic [`VRAM_WIDTH-1:0] addr1, addr2,
    input  logic                   we1, we2,
    input  logic [7:0]             data_in1, data_in2,
    output logic [7:0]             data_out1, data_out2
);

    logic [7:0] mem [2**`VRAM_WIDTH];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**`VRAM_WIDTH; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (clk_en) begin
            if (we1) begin
                mem[addr1] <= data_in1;
            end
            if (we2) begin
                mem[addr2] <= data_in2; // Port 2 wins on a clash
            end
        end
    end

    assign data_out1 = mem[addr1];
    assign data_out2 = mem[addr2];

endmodule

module pal_ram (
    input  logic                  clk,
    input  logic                  clk_en,
    input  logic                  rst_n,
    input  logic [`PAL_WIDTH-1:0] addr,
    input  logic                  we,
    input  logic [7:0]            data_in,
    output logic [7:0]            data_out
);

    logic [7:0] mem [2**`PAL_WIDTH]; // 8 palettes of 4 entries

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**`PAL_WIDTH; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (clk_en && we) begin
            mem[addr] <= data_in;
        end
    end

    assign data_out = mem[addr];

endmodule

module oam (
    input  logic                  clk,
    input  logic                  clk_en,
    input  logic                  rst_n,
    input  logic [`OAM_WIDTH-1:0] addr,
    input  logic                  we,
    input  logic [7:0]            data_in,
    output logic [7:0]            data_out
);

    logic [7:0] mem [2**`OAM_WIDTH]; // Y, tile, attr, X per sprite

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**`OAM_WIDTH; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (clk_en && we) begin
            mem[addr] <= data_in;
        end
    end

    assign data_out = mem[addr];

endmodule

// File: rtl/ppu_reg_port.sv
`include "ppu_mem_params.svh"

module ppu_reg_port import ppu_mem_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_en,
    input  cpu_req_t              cpu_req,
    output mem_wr_t               mem_acc,
    output logic [`OAM_WIDTH-1:0] oam_addr,
    output logic                  data_rd
);

    logic                       inc_32;      // Control bit 2
    logic                       addr_toggle; // 0 expects high byte
    ppu_addr_u                  vram_addr;
    logic                       wr_ctrl;
    logic                       wr_oamaddr;
    logic                       wr_oamdata;
    logic                       wr_addr;
    logic                       wr_data;
    logic                       data_acc;
    logic [`PPU_ADDR_WIDTH-1:0] addr_step;

    // Strobe decode, qualified by clk_en at the registers
    assign wr_ctrl    = cpu_req.wr && (cpu_req.reg_sel == REG_CTRL);
    assign wr_oamaddr = cpu_req.wr && (cpu_req.reg_sel == REG_OAMADDR);
    assign wr_oamdata = cpu_req.wr && (cpu_req.reg_sel == REG_OAMDATA);
    assign wr_addr    = cpu_req.wr && (cpu_req.reg_sel == REG_ADDR);
    assign wr_data    = cpu_req.wr && (cpu_req.reg_sel == REG_DATA);
    assign data_rd    = cpu_req.rd && (cpu_req.reg_sel == REG_DATA);
    assign data_acc   = wr_data || data_rd;

    assign addr_step = inc_32 ? `PPU_ADDR_WIDTH'd32 : `PPU_ADDR_WIDTH'd1; // Down a column or across

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            inc_32      <= 1'b0;
            addr_toggle <= 1'b0;
            vram_addr   <= '0;
            oam_addr    <= '0;
        end else if (clk_en) begin
            if (wr_ctrl) begin
                inc_32 <= cpu_req.wdata[2];
            end

            if (wr_oamaddr) begin
                oam_addr <= cpu_req.wdata;
            end else if (wr_oamdata) begin
                oam_addr <= oam_addr + 1'b1; // Wraps at 256
            end

            if (wr_addr) begin
                addr_toggle <= ~addr_toggle;
                if (!addr_toggle) begin
                    vram_addr.raw[`PPU_ADDR_WIDTH-1:8] <= cpu_req.wdata[`PPU_ADDR_WIDTH-9:0];
                end else begin
                    vram_addr.raw[7:0] <= cpu_req.wdata;
                end
            end else if (data_acc) begin
                // Any REG_DATA access steps the address, 14-bit wrap
                vram_addr.raw <= vram_addr.raw + addr_step;
            end
        end
    end

    // Access at the address as it stands before the edge
    assign mem_acc.addr   = vram_addr;
    assign mem_acc.data   = cpu_req.wdata;
    assign mem_acc.we     = wr_data;
    assign mem_acc.oam_we = wr_oamdata;

endmodule

// File: rtl/ppu_bus_map.sv
`include "ppu_mem_params.svh"

module ppu_bus_map import ppu_mem_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_en,
    input  logic                  mirror_vert, // 1 vertical, 0 horizontal
    input  mem_wr_t               mem_acc,
    input  logic [`OAM_WIDTH-1:0] oam_addr,
    input  ppu_addr_u             render_addr,
    output logic [7:0]            cpu_mem_data,
    output logic [7:0]            oam_data,
    output logic [7:0]            render_data
);

    logic                   cpu_is_pal;
    logic                   cpu_is_nt;
    logic [`CHR_WIDTH-1:0]  chr_addr1, chr_addr2;
    logic [`VRAM_WIDTH-1:0] vram_addr1, vram_addr2;
    logic [`PAL_WIDTH-1:0]  pal_addr;
    logic                   chr_we, vram_we, pal_we;
    logic [7:0]             chr_rd1, chr_rd2;
    logic [7:0]             vram_rd1, vram_rd2;
    logic [7:0]             pal_rd;

    function automatic logic [`CHR_WIDTH-1:0] chr_index(ppu_addr_u a);
        return {a.nt.region[0], a.nt.nt_sel, a.nt.offset};
    endfunction

    // Pick which nametable bit selects the physical table
    function automatic logic [`VRAM_WIDTH-1:0] vram_index(ppu_addr_u a, logic vert);
        return {(vert ? a.nt.nt_sel[0] : a.nt.nt_sel[1]), a.nt.offset};
    endfunction

    // Sprite backdrop entries fold onto the background ones
    function automatic logic [`PAL_WIDTH-1:0] pal_index(ppu_addr_u a);
        logic [`PAL_WIDTH-1:0] idx;
        idx = a.pal.pal_idx;
        if (idx[1:0] == 2'b00) begin
            idx[4] = 1'b0;
        end
        return idx;
    endfunction

    assign cpu_is_pal = (mem_acc.addr.pal.page[8:3] == 6'h3F); // 3F00 and up
    assign cpu_is_nt  = mem_acc.addr.nt.region[1];

    assign chr_addr1  = chr_index(mem_acc.addr);
    assign chr_addr2  = chr_index(render_addr);
    assign vram_addr1 = vram_index(mem_acc.addr, mirror_vert);
    assign vram_addr2 = vram_index(render_addr, mirror_vert); // 3000 up echoes 2000
    assign pal_addr   = pal_index(mem_acc.addr);

    assign chr_we  = mem_acc.we && !cpu_is_nt;
    assign vram_we = mem_acc.we && cpu_is_nt && !cpu_is_pal;
    assign pal_we  = mem_acc.we && cpu_is_pal;

    chr_ram chr_ram_inst (
        .clk(clk), .clk_en(clk_en), .rst_n(rst_n),
        .addr1(chr_addr1), .addr2(chr_addr2),
        .we1(chr_we), .data_in1(mem_acc.data),
        .data_out1(chr_rd1), .data_out2(chr_rd2)
    );

    vram vram_inst (
        .clk(clk), .clk_en(clk_en), .rst_n(rst_n),
        .addr1(vram_addr1), .addr2(vram_addr2),
        .we1(vram_we), .we2(1'b0), // Render side never writes
        .data_in1(mem_acc.data), .data_in2(8'h00),
        .data_out1(vram_rd1), .data_out2(vram_rd2)
    );

    pal_ram pal_ram_inst (
        .clk(clk), .clk_en(clk_en), .rst_n(rst_n),
        .addr(pal_addr), .we(pal_we), .data_in(mem_acc.data), .data_out(pal_rd)
    );

    oam oam_inst (
        .clk(clk), .clk_en(clk_en), .rst_n(rst_n),
        .addr(oam_addr), .we(mem_acc.oam_we), .data_in(mem_acc.data), .data_out(oam_data)
    );

    assign cpu_mem_data = cpu_is_pal ? pal_rd : (cpu_is_nt ? vram_rd1 : chr_rd1);
    assign render_data  = render_addr.nt.region[1] ? vram_rd2 : chr_rd2;

endmodule

// File: rtl/ppu_read_port.sv
module ppu_read_port import ppu_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clk_en,
    input  cpu_req_t   cpu_req,
    input  mem_wr_t    mem_acc,
    input  logic       data_rd,      // REG_DATA read this cycle
    input  logic [7:0] cpu_mem_data, // Mapped byte at current address
    input  logic [7:0] oam_data,
    output logic [7:0] cpu_rdata
);

    logic [7:0] rd_buf;
    logic       is_pal;

    assign is_pal = (mem_acc.addr.pal.page[8:3] == 6'h3F);

    // Buffer takes the byte at the old address as the address steps
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rd_buf <= 8'h00;
        end else if (clk_en && data_rd && !is_pal) begin
            rd_buf <= cpu_mem_data;
        end
    end

    always_comb begin
        cpu_rdata = 8'h00;
        if (cpu_req.rd) begin
            case (cpu_req.reg_sel)
                REG_DATA:    cpu_rdata = is_pal ? cpu_mem_data : rd_buf; // Palette skips the buffer
                REG_OAMDATA: cpu_rdata = oam_data;
                default:     cpu_rdata = 8'h00;
            endcase
        end
    end

endmodule

// File: rtl/ppu_mem_top.sv
`include "ppu_mem_params.svh"

module ppu_mem_top import ppu_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clk_en,      // One PPU cycle in four master cycles
    input  logic       mirror_vert, // From the cartridge
    input  cpu_req_t   cpu_req,
    output logic [7:0] cpu_rdata,
    input  ppu_addr_u  render_addr,
    output logic [7:0] render_data
);

    mem_wr_t               mem_acc;
    logic [`OAM_WIDTH-1:0] oam_addr;
    logic                  data_rd;
    logic [7:0]            cpu_mem_data;
    logic [7:0]            oam_data;

    ppu_reg_port ppu_reg_port_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .clk_en   (clk_en),
        .cpu_req  (cpu_req),
        .mem_acc  (mem_acc),
        .oam_addr (oam_addr),
        .data_rd  (data_rd)
    );

    ppu_bus_map ppu_bus_map_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_en       (clk_en),
        .mirror_vert  (mirror_vert),
        .mem_acc      (mem_acc),
        .oam_addr     (oam_addr),
        .render_addr  (render_addr),
        .cpu_mem_data (cpu_mem_data),
        .oam_data     (oam_data),
        .render_data  (render_data)
    );

    ppu_read_port ppu_read_port_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_en       (clk_en),
        .cpu_req      (cpu_req),
        .mem_acc      (mem_acc),
        .data_rd      (data_rd),
        .cpu_mem_data (cpu_mem_data),
        .oam_data     (oam_data),
        .cpu_rdata    (cpu_rdata)
    );

endmodule

// File: dv/ppu_mem_tb.sv
module ppu_mem_tb import ppu_mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_RENDER, OP_MIRROR} op_e;

    typedef struct packed {
        op_e         op;
        logic [2:0]  test;
        ppu_reg_e    reg_sel;
        logic [13:0] addr;  // Render address, or mirror level in bit 0
        logic [7:0]  data;
        logic [7:0]  exp;
        logic        check;
    } entry_t;

    logic       clk;
    logic       rst_n;
    logic       clk_en;
    logic       mirror_vert;
    cpu_req_t   cpu_req;
    ppu_addr_u  render_addr;
    logic [7:0] cpu_rdata;
    logic [7:0] render_data;

    entry_t      tbl[$];
    logic [31:0] lfsr;
    logic [1:0]  phase;
    bit          built;
    string       test_name[6];
    logic [2:0]  cur_test;
    int          errors, checks, tests_failed, test_errs, test_checks;

    // Reference model of the memories and register state
    logic [7:0]  m_chr[8192];
    logic [7:0]  m_vram[2048];
    logic [7:0]  m_pal[32];
    logic [7:0]  m_oam[256];
    logic [13:0] m_vaddr;
    logic [7:0]  m_buf, m_oamaddr;
    logic        m_toggle, m_inc32, m_mirror;

    ppu_mem_top ppu_mem_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_en      (clk_en),
        .mirror_vert (mirror_vert),
        .cpu_req     (cpu_req),
        .cpu_rdata   (cpu_rdata),
        .render_addr (render_addr),
        .render_data (render_data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // PPU clock enable is one master cycle in four
    always @(posedge clk) begin
        #1;
        phase = phase + 2'd1;
        clk_en = (phase == 2'd3);
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    // 3F10, 3F14, 3F18 and 3F1C fold onto 3F00, 3F04, 3F08 and 3F0C
    function automatic logic [4:0] pal_slot(logic [13:0] a);
        return (a[1:0] == 2'b00) ? {1'b0, a[3:0]} : a[4:0];
    endfunction

    function automatic logic [10:0] nt_slot(logic [13:0] a);
        return {(m_mirror ? a[10] : a[11]), a[9:0]};
    endfunction

    function automatic logic [7:0] model_read(logic [13:0] a, logic cpu_side);
        if (cpu_side && a >= 14'h3F00) begin
            return m_pal[pal_slot(a)];
        end else if (a[13]) begin
            return m_vram[nt_slot(a)];
        end
        return m_chr[a[12:0]];
    endfunction

    task automatic model_write(input logic [13:0] a, input logic [7:0] d);
        if (a >= 14'h3F00) begin
            m_pal[pal_slot(a)] = d;
        end else if (a[13]) begin
            m_vram[nt_slot(a)] = d;
        end else begin
            m_chr[a[12:0]] = d;
        end
    endtask

    task automatic push(input op_e op, input ppu_reg_e r, input logic [13:0] a,
                        input logic [7:0] d, input logic [7:0] e, input logic chk);
        entry_t t;
        t = '{op, cur_test, r, a, d, e, chk};
        tbl.push_back(t);
    endtask

    task automatic add_wr(input ppu_reg_e r, input logic [7:0] d);
        push(OP_WR, r, 14'h0000, d, 8'h00, 1'b0);
        case (r)
            REG_CTRL:    m_inc32 = d[2];
            REG_OAMADDR: m_oamaddr = d;
            REG_OAMDATA: begin
                m_oam[m_oamaddr] = d;
                m_oamaddr = m_oamaddr + 8'd1;
            end
            REG_ADDR: begin
                if (!m_toggle) begin
                    m_vaddr[13:8] = d[5:0];
                end else begin
                    m_vaddr[7:0] = d;
                end
                m_toggle = ~m_toggle;
            end
            REG_DATA: begin
                model_write(m_vaddr, d);
                m_vaddr = m_vaddr + (m_inc32 ? 14'd32 : 14'd1);
            end
            default: ;
        endcase
    endtask

    task automatic add_rd(input ppu_reg_e r);
        logic [7:0] e;
        e = 8'h00;
        if (r == REG_OAMDATA) begin
            e = m_oam[m_oamaddr];
        end else if (r == REG_DATA) begin
            if (m_vaddr >= 14'h3F00) begin
                e = model_read(m_vaddr, 1'b1); // Palette bypasses the buffer
            end else begin
                e = m_buf;
                m_buf = model_read(m_vaddr, 1'b1);
            end
            m_vaddr = m_vaddr + (m_inc32 ? 14'd32 : 14'd1);
        end
        push(OP_RD, r, 14'h0000, 8'h00, e, 1'b1);
    endtask

    task automatic add_render(input logic [13:0] a);
        push(OP_RENDER, REG_CTRL, a, 8'h00, model_read(a, 1'b0), 1'b1);
    endtask

    task automatic add_mirror(input logic v);
        m_mirror = v;
        push(OP_MIRROR, REG_CTRL, {13'h0000, v}, 8'h00, 8'h00, 1'b0);
    endtask

    task automatic set_addr(input logic [13:0] a);
        add_wr(REG_ADDR, {2'b00, a[13:8]});
        add_wr(REG_ADDR, a[7:0]);
    endtask

    task automatic build_table();
        logic [7:0] oa;
        cur_test = 3'd0; // Reset state
        add_rd(REG_DATA);
        add_render(14'h0000);
        add_render(14'h1234);
        add_render(14'h2000);
        add_render(14'h2FFF);
        cur_test = 3'd1; // Address and data port
        add_wr(REG_CTRL, 8'h00);
        set_addr(14'h2100);
        for (int i = 0; i < 8; i++) add_wr(REG_DATA, rand_byte());
        add_wr(REG_CTRL, 8'h04);
        for (int i = 0; i < 4; i++) add_wr(REG_DATA, rand_byte());
        add_wr(REG_CTRL, 8'h00);
        set_addr(14'h2100);
        for (int i = 0; i < 9; i++) add_rd(REG_DATA);
        add_rd(REG_ADDR); // Not readable, reads as zero
        add_wr(REG_CTRL, 8'h04);
        set_addr(14'h2108);
        for (int i = 0; i < 5; i++) add_rd(REG_DATA);
        cur_test = 3'd2; // Mirroring
        add_wr(REG_CTRL, 8'h00);
        add_mirror(1'b1);
        set_addr(14'h2000);
        add_wr(REG_DATA, rand_byte());
        add_render(14'h2000);
        add_render(14'h2800);
        add_render(14'h3000);
        add_render(14'h2400);
        add_mirror(1'b0);
        set_addr(14'h2010);
        add_wr(REG_DATA, rand_byte());
        add_render(14'h2010);
        add_render(14'h2410);
        add_render(14'h3010);
        add_render(14'h2810);
        cur_test = 3'd3; // Palette
        set_addr(14'h3F00);
        for (int i = 0; i < 32; i++) add_wr(REG_DATA, rand_byte());
        set_addr(14'h3F00);
        for (int i = 0; i < 32; i++) add_rd(REG_DATA);
        set_addr(14'h3F10);
        add_wr(REG_DATA, rand_byte());
        set_addr(14'h3F00);
        add_rd(REG_DATA);
        cur_test = 3'd4; // OAM run wraps past FF
        oa = 8'hF8;
        add_wr(REG_OAMADDR, oa);
        for (int i = 0; i < 16; i++) add_wr(REG_OAMDATA, rand_byte());
        for (int i = 0; i < 16; i++) begin
            add_wr(REG_OAMADDR, oa);
            add_rd(REG_OAMDATA);
            add_rd(REG_OAMDATA);
            oa = oa + 8'd1;
        end
        cur_test = 3'd5; // Whole CHR RAM
        set_addr(14'h0000);
        for (int i = 0; i < 8192; i++) add_wr(REG_DATA, rand_byte());
        for (int i = 0; i < 8192; i++) add_render(i[13:0]);
        set_addr(14'h0100); // CPU side of the pattern store
        for (int i = 0; i < 4; i++) begin
            add_rd(REG_DATA);
        end
    endtask

    task automatic apply(input entry_t t, input int idx);
        @(posedge clk);
        #1;
        cpu_req.wr      = (t.op == OP_WR);
        cpu_req.rd      = (t.op == OP_RD);
        cpu_req.reg_sel = t.reg_sel;
        cpu_req.wdata   = t.data;
        if (t.op == OP_RENDER) render_addr.raw = t.addr;
        if (t.op == OP_MIRROR) mirror_vert = t.addr[0];
        // Hold through the clk_en cycle and sample mid cycle
        do @(negedge clk); while (!clk_en);
        if (t.check) test_checks++;
        if (t.op == OP_RD && cpu_rdata !== t.exp) begin
            $display("ERR entry %0d cpu_rdata reg %h got %h exp %h",
                     idx, t.reg_sel, cpu_rdata, t.exp);
            test_errs++;
        end
        if (t.op == OP_RENDER && render_data !== t.exp) begin
            $display("ERR entry %0d render_data addr %h got %h exp %h",
                     idx, t.addr, render_data, t.exp);
            test_errs++;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        clk_en      = 1'b0;
        phase       = 2'd0;
        mirror_vert = 1'b1;
        cpu_req     = '0;
        render_addr = '0;
        lfsr        = 32'hc1f2;
        test_name   = '{"reset", "addr/data port", "mirroring", "palette", "oam", "chr ram"};
        foreach (m_chr[i]) m_chr[i] = 8'h00;
        foreach (m_vram[i]) m_vram[i] = 8'h00;
        foreach (m_pal[i]) m_pal[i] = 8'h00;
        foreach (m_oam[i]) m_oam[i] = 8'h00;
        m_vaddr  = 14'h0000;
        m_buf    = 8'h00;
        m_oamaddr = 8'h00;
        m_toggle = 1'b0;
        m_inc32  = 1'b0;
        m_mirror = 1'b1;
        build_table();
        built = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            apply(tbl[i], i);
            if (i == tbl.size() - 1 || tbl[i + 1].test != tbl[i].test) begin
                $display("test %0d %s: %0d checks, %0d errors", tbl[i].test + 1,
                         test_name[tbl[i].test], test_checks, test_errs);
                if (test_errs != 0) tests_failed++;
                errors += test_errs;
                checks += test_checks;
                test_errs   = 0;
                test_checks = 0;
            end
        end
        @(posedge clk);
        #1;
        cpu_req = '0;
        $display("tests 6, failing %0d, checks %0d, errors %0d", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Eight clk_en periods per entry plus reset time
    initial begin
        wait (built);
        #(tbl.size() * 8 * 40 + 50 + 100);
        $display("Watchdog expired before the stimulus table finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: all.f
+incdir+rtl
rtl/ppu_mem_pkg.sv
rtl/ppu_mems.sv
rtl/ppu_reg_port.sv
rtl/ppu_bus_map.sv
rtl/ppu_read_port.sv
rtl/ppu_mem_top.sv
dv/ppu_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PPU memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module ppu_mem_tb -Mdir obj_dir -o ppu_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out="$(./obj_dir/ppu_mem_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
